// ==== rvDefines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// First fetch address after reset
`define RV_RESET_ADDR 32'h0000_0000

// Meaningful byte address bits, the bus pads the rest with zero
`define RV_ADDR_WIDTH 24

// Divider iterations, one per quotient bit
`define RV_DIV_STEPS 32

`endif

// ==== rvPkg.sv ====
`include "rvDefines.svh"

package rvPkg;

   typedef logic [31:0]               word_t;       // Data word, register value
   typedef logic [`RV_ADDR_WIDTH-1:0] addr_t;       // Byte address inside the core
   typedef logic [4:0]                regId_t;      // Register index x0..x31
   typedef logic [4:0]                shamt_t;      // Shift amount
   typedef logic [7:0]                funct3Hot_t;  // Bit n set when funct3 == n

   // Sequencer states, one-hot
   typedef enum logic [3:0] {
      FetchInstr   = 4'b0001,  // Strobe the instruction read
      WaitInstr    = 4'b0010,  // Wait for the word, latch it, read registers
      Execute      = 4'b0100,  // New PC, write back, start memory or divide
      WaitAluOrMem = 4'b1000   // Divider and memory bus settle
   } cpuState_t;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
   input  rvPkg::word_t      instr,       // Latched instruction
   input  rvPkg::word_t      memRdata,    // Word on the bus during WaitInstr
   output logic              isLoad,
   output logic              isStore,
   output logic              isBranch,
   output logic              isJal,
   output logic              isJalr,
   output logic              isAuipc,
   output logic              isLui,
   output logic              isAlu,
   output logic              isMulDiv,
   output logic              isDivide,
   output rvPkg::funct3Hot_t funct3Is,
   output rvPkg::regId_t     rdId,
   output rvPkg::regId_t     rs1Id,
   output rvPkg::regId_t     rs2Id,
   output rvPkg::word_t      iImm,
   output rvPkg::word_t      sImm,
   output rvPkg::word_t      immPc,       // Offset for the PC adder
   output logic              aluRegForm,  // Second operand is rs2
   output logic              subOrArith   // SUB, SRA, SRAI
);
   import rvPkg::*;

   word_t uImm;
   word_t bImm;
   word_t jImm;
   logic  isAluImm;
   logic  isAluReg;

   // Base opcodes, bits 1:0 are always 11
   assign isLoad   = (instr[6:2] == 5'b00000);  // rd <- mem[rs1+iImm]
   assign isAluImm = (instr[6:2] == 5'b00100);  // rd <- rs1 OP iImm
   assign isAuipc  = (instr[6:2] == 5'b00101);  // rd <- PC + uImm
   assign isStore  = (instr[6:2] == 5'b01000);  // mem[rs1+sImm] <- rs2
   assign isAluReg = (instr[6:2] == 5'b01100);  // rd <- rs1 OP rs2
   assign isLui    = (instr[6:2] == 5'b01101);  // rd <- uImm
   assign isBranch = (instr[6:2] == 5'b11000);
   assign isJalr   = (instr[6:2] == 5'b11001);  // rd <- PC+4, PC <- rs1+iImm
   assign isJal    = (instr[6:2] == 5'b11011);  // rd <- PC+4, PC <- PC+jImm
   assign isAlu    = isAluImm | isAluReg;

   // M extension, funct7 = 0000001
   assign isMulDiv = isAluReg & instr[25];
   assign isDivide = isMulDiv & instr[14];      // DIV, DIVU, REM, REMU

   assign funct3Is = 8'b0000_0001 << instr[14:12];

   assign rdId  = instr[11:7];
   // Source indexes come straight from the bus, the word is not latched yet
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign uImm = {instr[31:12], 12'b0};

   // JAL has bit 3 set, AUIPC bit 4, branches neither
   assign immPc = instr[3] ? jImm : instr[4] ? uImm : bImm;

   assign aluRegForm = isAluReg | isBranch;     // Compare needs rs2
   assign subOrArith = instr[30];

endmodule

// ==== registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
   input  logic          clk,
   input  logic          decodeEn,       // Capture both read ports
   input  rvPkg::regId_t rs1Id,
   input  rvPkg::regId_t rs2Id,
   input  logic          writeBack,
   input  rvPkg::regId_t rdId,
   input  rvPkg::word_t  writeBackData,
   output rvPkg::word_t  rs1Data,
   output rvPkg::word_t  rs2Data
);

   logic [31:0] regs [32];  // Entry 0 never written

   always_ff @(posedge clk) begin
      if (decodeEn) begin
         rs1Data <= (rs1Id == '0) ? '0 : regs[rs1Id];  // x0 reads as zero
         rs2Data <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
      if (writeBack && rdId != '0) begin
         regs[rdId] <= writeBackData;
      end
   end

   // Decode and write-back sit in different sequencer states
   assert property (@(posedge clk) writeBack |-> !decodeEn)
      else $error("Register write during decode");

endmodule

// ==== intAlu.sv ====
`timescale 1ns/10ps

module intAlu (
   input  rvPkg::word_t      rs1Data,
   input  rvPkg::word_t      rs2Data,
   input  rvPkg::word_t      iImm,
   input  rvPkg::funct3Hot_t funct3Is,
   input  logic              aluRegForm,  // rs2 instead of iImm
   input  logic              subOrArith,  // instr[30]
   input  logic              isMulDiv,
   input  rvPkg::word_t      divResult,   // Unsigned magnitude from the divider
   input  logic              divNegate,
   output rvPkg::word_t      aluPlus,     // Also the JALR target
   output rvPkg::word_t      aluOut,
   output logic              predicate    // Branch taken
);
   import rvPkg::*;

   word_t              aluIn2;
   logic [32:0]        aluMinus;
   logic               lt;
   logic               ltu;
   logic               eq;
   shamt_t             shamt;
   word_t              shifterIn;
   logic [32:0]        shiftWide;
   word_t              shifter;
   word_t              leftShift;
   logic signed [32:0] mulIn1;
   logic signed [32:0] mulIn2;
   logic signed [65:0] product;
   word_t              baseOut;
   word_t              mulDivOut;

   function automatic word_t flip32(input word_t x);
      word_t y;
      for (int i = 0; i < 32; i++) begin
         y[i] = x[31-i];
      end
      return y;
   endfunction

   assign aluIn2  = aluRegForm ? rs2Data : iImm;
   assign aluPlus = rs1Data + aluIn2;

   // Single 33-bit subtract for SUB and every comparison
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Data} + 33'd1;
   assign ltu      = aluMinus[32];                     // Set when rs1 < rs2 unsigned
   assign lt       = (rs1Data[31] ^ aluIn2[31]) ? rs1Data[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == '0);

   // One right shifter, left shifts go through bit reversal
   assign shamt     = aluIn2[4:0];
   assign shifterIn = funct3Is[1] ? flip32(rs1Data) : rs1Data;
   assign shiftWide = $signed({subOrArith & rs1Data[31], shifterIn}) >>> shamt;
   assign shifter   = shiftWide[31:0];
   assign leftShift = flip32(shifter);

   // MULH signs both operands, MULHSU only rs1, MULHU none
   assign mulIn1  = {rs1Data[31] & (funct3Is[1] | funct3Is[2]), rs1Data};
   assign mulIn2  = {aluIn2[31] & funct3Is[1], aluIn2};
   assign product = mulIn1 * mulIn2;

   assign baseOut =
      (funct3Is[0] ? ((subOrArith & aluRegForm) ? aluMinus[31:0] : aluPlus) : '0) |
      (funct3Is[1] ? leftShift          : '0) |
      (funct3Is[2] ? {31'b0, lt}        : '0) |
      (funct3Is[3] ? {31'b0, ltu}       : '0) |
      (funct3Is[4] ? rs1Data ^ aluIn2   : '0) |
      (funct3Is[5] ? shifter            : '0) |  // SRL, SRA
      (funct3Is[6] ? rs1Data | aluIn2   : '0) |
      (funct3Is[7] ? rs1Data & aluIn2   : '0);

   assign mulDivOut =
      (funct3Is[0]    ? product[31:0]  : '0) |   // MUL
      (|funct3Is[3:1] ? product[63:32] : '0) |   // MULH, MULHSU, MULHU
      (|funct3Is[7:4] ? (divNegate ? -divResult : divResult) : '0);

   assign aluOut = isMulDiv ? mulDivOut : baseOut;

   assign predicate =
      (funct3Is[0] &  eq)  |  // BEQ
      (funct3Is[1] & !eq)  |  // BNE
      (funct3Is[4] &  lt)  |  // BLT
      (funct3Is[5] & !lt)  |  // BGE
      (funct3Is[6] &  ltu) |  // BLTU
      (funct3Is[7] & !ltu);   // BGEU

endmodule

// ==== serialDivider.sv ====
`timescale 1ns/10ps
`include "rvDefines.svh"

module serialDivider (
   input  logic         clk,
   input  logic         reset,
   input  logic         divStart,       // One cycle, Execute of a divide
   input  rvPkg::word_t rs1Data,        // Dividend
   input  rvPkg::word_t rs2Data,        // Divisor
   input  logic         divSigned,      // DIV, REM
   input  logic         wantRemainder,  // REM, REMU
   output rvPkg::word_t divResult,      // Quotient or remainder magnitude
   output logic         divNegate,      // Sign fix applied in the ALU
   output logic         divBusy
);
   import rvPkg::*;

   word_t                      dividend;      // Becomes the remainder
   logic [2*`RV_DIV_STEPS-2:0] divisor;       // Left aligned at start, moves right
   word_t                      quotient;
   word_t                      quotMask;      // Quotient bit being decided
   word_t                      dividendAbs;
   word_t                      divisorAbs;
   logic                       stepDo;
   word_t                      dividendNext;
   word_t                      quotientNext;

   assign dividendAbs = (divSigned & rs1Data[31]) ? -rs1Data : rs1Data;
   assign divisorAbs  = (divSigned & rs2Data[31]) ? -rs2Data : rs2Data;

   assign stepDo       = (divisor <= {{(`RV_DIV_STEPS-1){1'b0}}, dividend});
   assign dividendNext = stepDo ? dividend - divisor[31:0] : dividend;
   assign quotientNext = stepDo ? quotient | quotMask : quotient;
   assign divBusy      = |quotMask;

   // Quotient negative when signs differ and divisor non-zero, remainder follows dividend
   assign divNegate = divSigned & (wantRemainder ? rs1Data[31]
                                                 : (rs1Data[31] != rs2Data[31]) & |rs2Data);

   always_ff @(posedge clk) begin
      if (!reset) begin
         quotMask <= '0;
      end else if (divStart) begin
         quotMask <= word_t'(1) << (`RV_DIV_STEPS - 1);
      end else begin
         quotMask <= quotMask >> 1;   // Empty after the last step
      end
   end

   always_ff @(posedge clk) begin
      if (divStart) begin
         dividend <= dividendAbs;
         divisor  <= {divisorAbs, {(`RV_DIV_STEPS-1){1'b0}}};
         quotient <= '0;
      end else begin
         dividend <= dividendNext;
         divisor  <= divisor >> 1;
         quotient <= quotientNext;
      end
      if (divBusy) begin
         divResult <= wantRemainder ? dividendNext : quotientNext;  // Frozen after the last step
      end
   end

   assert property (@(posedge clk) disable iff (!reset) divStart |-> !divBusy)
      else $error("Divide started while divider busy");

endmodule

// ==== loadStoreUnit.sv ====
`timescale 1ns/10ps
`include "rvDefines.svh"

module loadStoreUnit (
   input  rvPkg::word_t rs1Data,       // Base address
   input  rvPkg::word_t rs2Data,       // Store data
   input  rvPkg::word_t iImm,
   input  rvPkg::word_t sImm,
   input  logic         isStore,
   input  logic [1:0]   accessSize,    // 00 byte, 01 halfword, 10 word
   input  logic         loadUnsigned,  // LBU, LHU
   input  logic         storeEn,       // Execute of a store
   input  rvPkg::word_t memRdata,
   output rvPkg::addr_t lsAddr,
   output rvPkg::word_t memWdata,
   output logic [3:0]   memWmask,
   output rvPkg::word_t loadData
);
   import rvPkg::*;

   word_t       offset;
   logic        byteAccess;
   logic        halfAccess;
   logic [3:0]  storeMask;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign offset = isStore ? sImm : iImm;
   assign lsAddr = rs1Data[`RV_ADDR_WIDTH-1:0] + offset[`RV_ADDR_WIDTH-1:0];

   assign byteAccess = (accessSize == 2'b00);
   assign halfAccess = (accessSize == 2'b01);

   // Low byte or halfword copied into every lane it may land in
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = lsAddr[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = lsAddr[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = lsAddr[0] ? rs2Data[7:0] :
                            lsAddr[1] ? rs2Data[15:8] : rs2Data[31:24];

   assign storeMask = byteAccess ? 4'b0001 << lsAddr[1:0] :
                      halfAccess ? (lsAddr[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;
   assign memWmask  = {4{storeEn}} & storeMask;

   // Pick the addressed lane, then extend
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !loadUnsigned & (byteAccess ? loadByte[7] : loadHalf[15]);
   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

endmodule

// ==== fetchSequencer.sv ====
`timescale 1ns/10ps
`include "rvDefines.svh"

module fetchSequencer (
   input  logic         clk,
   input  logic         reset,
   input  rvPkg::word_t memRdata,
   input  logic         memRbusy,
   input  logic         memWbusy,
   input  logic         divBusy,
   input  logic         isLoad,
   input  logic         isStore,
   input  logic         isBranch,
   input  logic         isJal,
   input  logic         isJalr,
   input  logic         isAuipc,
   input  logic         isLui,
   input  logic         isAlu,
   input  logic         isDivide,
   input  rvPkg::word_t immPc,          // Branch, JAL or AUIPC offset
   input  rvPkg::word_t aluPlus,        // rs1 + iImm for JALR
   input  logic         predicate,
   input  rvPkg::word_t aluOut,
   input  rvPkg::word_t loadData,
   input  rvPkg::addr_t lsAddr,
   output rvPkg::word_t instr,
   output logic         decodeEn,
   output logic         writeBack,
   output rvPkg::word_t writeBackData,
   output logic         divStart,
   output logic         memRstrb,
   output logic         storeEn,
   output rvPkg::addr_t fetchAddr       // Bus address before padding
);
   import rvPkg::*;

   cpuState_t state;
   addr_t     pc;
   addr_t     pcPlus4;
   addr_t     pcPlusImm;
   addr_t     nextPc;
   word_t     uImm;
   logic      needToWait;

   assign pcPlus4   = pc + addr_t'(4);
   assign pcPlusImm = pc + immPc[`RV_ADDR_WIDTH-1:0];
   assign uImm      = {instr[31:12], 12'b0};

   assign nextPc = isJalr                     ? {aluPlus[`RV_ADDR_WIDTH-1:1], 1'b0} :
                   (isJal | isBranch & predicate) ? pcPlusImm :
                                                pcPlus4;

   assign needToWait = isLoad | isStore | isDivide;

   assign decodeEn  = (state == WaitInstr) & !memRbusy;
   assign memRstrb  = (state == FetchInstr) | ((state == Execute) & isLoad);
   assign storeEn   = (state == Execute) & isStore;
   assign divStart  = (state == Execute) & isDivide;
   // Loads and divides keep writing through the wait, the last value stands
   assign writeBack = !(isBranch | isStore) & ((state == Execute) | (state == WaitAluOrMem));

   assign fetchAddr = ((state == FetchInstr) | (state == WaitInstr)) ?
                      {pc[`RV_ADDR_WIDTH-1:2], 2'b00} : lsAddr;

   assign writeBackData =
      (isLui          ? uImm              : '0) |
      (isAuipc        ? word_t'(pc) + immPc : '0) |  // Full width sum
      (isAlu          ? aluOut            : '0) |
      (isJal | isJalr ? word_t'(pcPlus4)  : '0) |    // Link address
      (isLoad         ? loadData          : '0);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= WaitAluOrMem;                 // First waits for memWbusy low
         pc    <= addr_t'(`RV_RESET_ADDR);
      end else begin
         case (state)
            FetchInstr: begin
               state <= WaitInstr;
            end
            WaitInstr: begin
               if (!memRbusy) begin
                  state <= Execute;
               end
            end
            Execute: begin
               pc    <= nextPc;
               state <= needToWait ? WaitAluOrMem : FetchInstr;
            end
            default: begin                      // WaitAluOrMem
               if (!divBusy && !memRbusy && !memWbusy) begin
                  state <= FetchInstr;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (decodeEn) begin
         instr <= memRdata;
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state))
      else $error("Sequencer state not one-hot");
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && storeEn))
      else $error("Read strobe and store in the same cycle");

endmodule

// ==== rvCore.sv ====
`timescale 1ns/10ps

module rvCore (
   input  logic         clk,
   input  logic         reset,
   output rvPkg::word_t memAddr,
   output rvPkg::word_t memWdata,
   output logic [3:0]   memWmask,
   input  rvPkg::word_t memRdata,
   output logic         memRstrb,
   input  logic         memRbusy,
   input  logic         memWbusy
);
   import rvPkg::*;

   word_t      instr;
   logic       isLoad;
   logic       isStore;
   logic       isBranch;
   logic       isJal;
   logic       isJalr;
   logic       isAuipc;
   logic       isLui;
   logic       isAlu;
   logic       isMulDiv;
   logic       isDivide;
   funct3Hot_t funct3Is;
   regId_t     rdId;
   regId_t     rs1Id;
   regId_t     rs2Id;
   word_t      iImm;
   word_t      sImm;
   word_t      immPc;
   logic       aluRegForm;
   logic       subOrArith;
   logic       decodeEn;
   logic       writeBack;
   word_t      writeBackData;
   word_t      rs1Data;
   word_t      rs2Data;
   word_t      aluPlus;
   word_t      aluOut;
   logic       predicate;
   word_t      divResult;
   logic       divNegate;
   logic       divBusy;
   logic       divStart;
   logic       storeEn;
   addr_t      lsAddr;
   addr_t      fetchAddr;
   word_t      loadData;

   assign memAddr = word_t'(fetchAddr);   // Upper bits zero

   fetchSequencer i_sequencer (.*);
   instrDecoder   i_decoder (.*);
   registerFile   i_regs (.*);
   intAlu         i_alu (.*);

   // funct3 bit 0 clear for the signed forms, bit 1 set for remainders
   serialDivider i_divider (
      .divSigned     (~instr[12]),
      .wantRemainder (instr[13]),
      .*
   );

   loadStoreUnit i_lsu (
      .accessSize   (instr[13:12]),
      .loadUnsigned (instr[14]),
      .*
   );

endmodule

// ==== tbVectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: name, six program words, data at 0x80 and 0x84, store address, mask, data
string      names[48];
word_t      progs[48][6];
word_t      data0[48];
word_t      data1[48];
word_t      expAddr[48];
logic [3:0] expMask[48];
word_t      expData[48];
int         numTests = 0;

localparam word_t LoadX1 = 32'h0800_2083;  // lw x1, 0x80(x0)
localparam word_t LoadX2 = 32'h0840_2103;  // lw x2, 0x84(x0)
localparam word_t StoreX3 = 32'h0830_2423; // sw x3, 0x88(x0)
localparam word_t Addi7 = 32'h0070_0193;   // addi x3, x0, 7
localparam word_t Addi1 = 32'h0010_0193;   // addi x3, x0, 1
localparam word_t Nop = 32'h0000_0013;
localparam word_t ValA = 32'h8765_4321;

task automatic addTest(input string name, input word_t p0, p1, p2, p3, p4, p5,
                       input word_t d0, d1, addr, input logic [3:0] mask, input word_t data);
   names[numTests]   = name;
   progs[numTests]   = '{p0, p1, p2, p3, p4, p5};
   data0[numTests]   = d0;
   data1[numTests]   = d1;
   expAddr[numTests] = addr;
   expMask[numTests] = mask;
   expData[numTests] = data;
   numTests++;
endtask

// x3 = x1 OP x2, stored to 0x88
task automatic addAlu(input string name, input word_t op, d0, d1, result);
   addTest(name, LoadX1, LoadX2, op, StoreX3, 0, 0, d0, d1, 32'h88, 4'hf, result);
endtask

task automatic addStore(input string name, input word_t op, addr, input logic [3:0] mask,
                        input word_t data);
   addTest(name, LoadX1, op, 0, 0, 0, 0, ValA, 5, addr, mask, data);
endtask

task automatic buildTable();
   addAlu("add", 32'h0020_81b3, ValA, 5, 32'h8765_4326);
   addAlu("sub", 32'h4020_81b3, ValA, 5, 32'h8765_431c);
   addAlu("sll", 32'h0020_91b3, ValA, 5, 32'heca8_6420);
   addAlu("slt", 32'h0020_a1b3, ValA, 5, 32'h1);
   addAlu("sltu", 32'h0020_b1b3, ValA, 5, 32'h0);
   addAlu("xor", 32'h0020_c1b3, ValA, 5, 32'h8765_4324);
   addAlu("srl", 32'h0020_d1b3, ValA, 5, 32'h043b_2a19);
   addAlu("sra", 32'h4020_d1b3, ValA, 5, 32'hfc3b_2a19);
   addAlu("or", 32'h0020_e1b3, ValA, 5, 32'h8765_4325);
   addAlu("and", 32'h0020_f1b3, ValA, 5, 32'h1);
   addAlu("addi", 32'hfff0_8193, ValA, 5, 32'h8765_4320);
   addAlu("srai", 32'h4040_d193, ValA, 5, 32'hf876_5432);
   addAlu("mul", 32'h0220_81b3, ValA, 5, 32'ha4fa_4fa5);
   addAlu("mulh", 32'h0220_91b3, ValA, 5, 32'hffff_fffd);
   addAlu("mulhsu", 32'h0220_a1b3, ValA, 5, 32'hffff_fffd);
   addAlu("mulhu", 32'h0220_b1b3, ValA, 5, 32'h2);
   addAlu("mulh neg rs2", 32'h0220_91b3, 5, ValA, 32'hffff_fffd);
   addAlu("mulhsu neg rs2", 32'h0220_a1b3, 5, ValA, 32'h2);   // rs2 taken unsigned
   addAlu("div", 32'h0220_c1b3, -32'sd100, 7, -32'sd14);
   addAlu("divu", 32'h0220_d1b3, -32'sd100, 7, 32'h2492_4916);
   addAlu("rem", 32'h0220_e1b3, -32'sd100, 7, -32'sd2);
   addAlu("remu", 32'h0220_f1b3, -32'sd100, 7, 32'h2);
   addAlu("div neg divisor", 32'h0220_c1b3, 100, -32'sd7, -32'sd14);
   addAlu("rem neg divisor", 32'h0220_e1b3, 100, -32'sd7, 32'h2);
   addAlu("div by zero", 32'h0220_c1b3, -32'sd100, 0, 32'hffff_ffff);
   addAlu("rem by zero", 32'h0220_e1b3, -32'sd100, 0, -32'sd100);
   addAlu("lb", 32'h0830_0183, ValA, 5, 32'hffff_ff87);
   addAlu("lbu", 32'h0830_4183, ValA, 5, 32'h87);
   addAlu("lh", 32'h0820_1183, ValA, 5, 32'hffff_8765);
   addAlu("lhu", 32'h0820_5183, ValA, 5, 32'h8765);
   addAlu("lb low", 32'h0800_0183, ValA, 5, 32'h21);
   addAlu("lhu low", 32'h0800_5183, ValA, 5, 32'h4321);
   addTest("lui", 32'h1234_51b7, StoreX3, 0, 0, 0, 0, ValA, 5, 32'h88, 4'hf, 32'h1234_5000);
   addTest("auipc", Nop, 32'h0000_1197, StoreX3, 0, 0, 0, ValA, 5, 32'h88, 4'hf, 32'h1004);
   addTest("jal", 32'h0080_01ef, Addi1, StoreX3, 0, 0, 0, ValA, 5, 32'h88, 4'hf, 32'h4);
   addTest("jalr", Nop, 32'h00c0_01e7, Addi1, StoreX3, 0, 0, ValA, 5, 32'h88, 4'hf, 32'h8);
   addTest("blt taken", LoadX1, LoadX2, Addi7, 32'h0020_c463, Addi1, StoreX3,
           ValA, 5, 32'h88, 4'hf, 32'h7);
   addTest("bgeu taken", LoadX1, LoadX2, Addi7, 32'h0020_f463, Addi1, StoreX3,
           ValA, 5, 32'h88, 4'hf, 32'h7);
   addTest("beq not taken", LoadX1, LoadX2, Addi7, 32'h0020_8463, Addi1, StoreX3,
           ValA, 5, 32'h88, 4'hf, 32'h1);
   addStore("sb 0x88", 32'h0810_0423, 32'h88, 4'b0001, 32'h0000_0021);
   addStore("sb 0x89", 32'h0810_04a3, 32'h89, 4'b0010, 32'h0000_2100);
   addStore("sb 0x8a", 32'h0810_0523, 32'h8a, 4'b0100, 32'h0021_0000);
   addStore("sb 0x8b", 32'h0810_05a3, 32'h8b, 4'b1000, 32'h2100_0000);
   addStore("sh 0x88", 32'h0810_1423, 32'h88, 4'b0011, 32'h0000_4321);
   addStore("sh 0x8a", 32'h0810_1523, 32'h8a, 4'b1100, 32'h4321_0000);
endtask

`endif

// ==== tbRvCore.sv ====
`timescale 1ns/10ps

module tbRvCore;
   import rvPkg::*;

   logic       clk;
   logic       reset;
   word_t      memAddr;
   word_t      memWdata;
   logic [3:0] memWmask;
   word_t      memRdata;
   logic       memRstrb;
   logic       memRbusy;
   logic       memWbusy;
   word_t      mem[64];
   word_t      rdAddr;
   logic [31:0] lfsr = 32'hbb6c9824;
   logic       lastStrobe = 1'b0;         // Read strobe seen at the previous falling edge

   `include "tbVectors.svh"

   rvCore i_dut (.*);

   always #5 clk = ~clk;

   // Galois LFSR, one step per bit taken
   function automatic logic randomBit();
      logic b;
      b    = lfsr[0];
      lfsr = b ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      return b;
   endfunction

   // Memory model, read answered from the address of the last strobe
   always @(negedge clk) begin
      assert (!(memRstrb && lastStrobe)) else
         failRun("Read strobe stayed high for more than one cycle");
      lastStrobe = memRstrb;
      if (memRstrb) rdAddr = memAddr;
      memRdata <= mem[rdAddr[7:2]];
      memRbusy <= randomBit() & randomBit();   // Busy a quarter of the cycles
      memWbusy <= randomBit() & randomBit();
   end

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic checkValue(input string test, input string what, input word_t exp,
                             input word_t act);
      assert (exp == act) else
         failRun($sformatf("Error %s %s expected %h actual %h", test, what, exp, act));
   endtask

   function automatic word_t laneBits(input logic [3:0] mask);
      return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   task automatic runTest(input int t);
      int cycles;
      reset = 1'b0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = 32'ha500_0000 | i;               // Unused words differ per address
      end
      for (int i = 0; i < 6; i++) begin
         mem[i] = progs[t][i];
      end
      mem[32] = data0[t];
      mem[33] = data1[t];
      repeat (2) @(negedge clk);
      reset = 1'b1;
      for (cycles = 0; cycles < 2000 && memWmask == '0; cycles++) begin
         @(negedge clk);
      end
      if (memWmask == '0) begin
         failRun($sformatf("Test %s timed out waiting for a store", names[t]));
      end
      checkValue(names[t], "address", expAddr[t], memAddr);
      checkValue(names[t], "mask", word_t'(expMask[t]), word_t'(memWmask));
      checkValue(names[t], "data", expData[t] & laneBits(expMask[t]),
                 memWdata & laneBits(memWmask));
   endtask

   initial begin
      clk      = 1'b0;
      reset    = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      rdAddr   = '0;
      buildTable();
      @(negedge clk);
      for (int t = 0; t < numTests; t++) begin
         runTest(t);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
rvPkg.sv
instrDecoder.sv
registerFile.sv
intAlu.sv
serialDivider.sv
loadStoreUnit.sv
fetchSequencer.sv
rvCore.sv
tbRvCore.sv
